// File: gb_io.f
+incdir+tests
rtl/gb_mem_pkg.sv
rtl/gb_irq_pkg.sv
rtl/gb_cpu_bus_if.sv
rtl/gb_irq_if.sv
rtl/gb_addr_decode.sv
rtl/gb_irq_ctrl.sv
rtl/gb_sys_regs.sv
rtl/gb_read_mux.sv
rtl/gb_io_top.sv
tests/tb_gb_io.sv

// File: rtl/gb_addr_decode.sv
module gb_addr_decode (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              ce_cpu,
	input  gb_mem_pkg::addr_t cpu_addr,
	input  gb_mem_pkg::data_t cpu_do,
	input  logic              cpu_wr_n,
	input  logic              is_gbc,
	input  logic              is_gbc_game,
	input  logic              boot_rom_enabled,
	gb_cpu_bus_if.dec         bus
);

	logic old_wr_n; // write line seen on the last ce cycle

	assign bus.addr     = cpu_addr;
	assign bus.wdata    = cpu_do;
	assign bus.is_gbc   = is_gbc;
	assign bus.gbc_mode = is_gbc_game | boot_rom_enabled; // boot rom runs in colour mode

	// ----------------------------------------
	// write strobe
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			old_wr_n <= 1'b1; // idle level
		end else if (ce_cpu) begin
			old_wr_n <= cpu_wr_n;
		end
	end

	// falling edge of wr_n, one cycle even if wr_n stays low
	assign bus.wr_stb = ce_cpu & old_wr_n & ~cpu_wr_n;

	// ----------------------------------------
	// address to select
	// ----------------------------------------
	always_comb begin
		bus.sel = gb_mem_pkg::sel_none;
		if (bus.addr < gb_mem_pkg::addr_io_base) begin
			bus.sel = gb_mem_pkg::sel_ext; // rom .. oam
		end else if (bus.addr >= gb_mem_pkg::addr_hram_base &&
				bus.addr != gb_mem_pkg::addr_ie) begin
			bus.sel = gb_mem_pkg::sel_ext; // zero page ram
		end else begin
			case (bus.addr)
				gb_mem_pkg::addr_joy:  bus.sel = gb_mem_pkg::sel_joy;
				gb_mem_pkg::addr_if:   bus.sel = gb_mem_pkg::sel_if;
				gb_mem_pkg::addr_ie:   bus.sel = gb_mem_pkg::sel_ie;
				gb_mem_pkg::addr_boot: bus.sel = gb_mem_pkg::sel_boot;
				gb_mem_pkg::addr_key1: begin
					if (is_gbc && is_gbc_game)
						bus.sel = gb_mem_pkg::sel_key1; // cgb mode only
				end
				gb_mem_pkg::addr_vbk: begin
					if (is_gbc)
						bus.sel = gb_mem_pkg::sel_vbk;
				end
				gb_mem_pkg::addr_svbk: begin
					if (is_gbc && bus.gbc_mode)
						bus.sel = gb_mem_pkg::sel_svbk;
				end
				gb_mem_pkg::addr_ff72: begin
					if (is_gbc)
						bus.sel = gb_mem_pkg::sel_ff72;
				end
				gb_mem_pkg::addr_ff73: begin
					if (is_gbc)
						bus.sel = gb_mem_pkg::sel_ff73;
				end
				gb_mem_pkg::addr_ff74: begin
					if (is_gbc && is_gbc_game)
						bus.sel = gb_mem_pkg::sel_ff74; // only for colour games
				end
				gb_mem_pkg::addr_ff75: begin
					if (is_gbc)
						bus.sel = gb_mem_pkg::sel_ff75;
				end
				default: bus.sel = gb_mem_pkg::sel_none; // other io, reads open
			endcase
		end
	end

endmodule

// File: rtl/gb_cpu_bus_if.sv
interface gb_cpu_bus_if;

	gb_mem_pkg::addr_t   addr;     // cpu address
	gb_mem_pkg::data_t   wdata;    // cpu write data
	gb_mem_pkg::io_sel_e sel;      // decoded target
	logic                wr_stb;   // single cycle write
	logic                is_gbc;   // colour hardware
	logic                gbc_mode; // colour game or still in boot rom

	// decoder owns the whole bundle
	modport dec (
		output addr,
		output wdata,
		output sel,
		output wr_stb,
		output is_gbc,
		output gbc_mode
	);

	// register stages, irq controller included
	modport regs (
		input wdata,
		input sel,
		input wr_stb,
		input is_gbc
	);

	// read side only needs the select
	modport mux (
		input sel
	);

endinterface

// File: rtl/gb_io_top.sv
module gb_io_top (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  logic                   ce_cpu,
	input  logic                   is_gbc,
	input  logic                   is_gbc_game,
	input  gb_mem_pkg::addr_t      cpu_addr,
	input  gb_mem_pkg::data_t      cpu_do,
	input  logic                   cpu_wr_n,
	input  logic                   cpu_rd_n, // reads are not strobed, cpu_di follows the address
	input  logic                   cpu_iorq_n,
	input  logic                   cpu_m1_n,
	input  logic                   cpu_stop,
	input  gb_mem_pkg::data_t      ext_di,
	input  logic [3:0]             joy_din,
	input  logic                   vblank_irq,
	input  logic                   video_irq,
	input  logic                   timer_irq,
	input  logic                   serial_irq,
	output gb_mem_pkg::data_t      cpu_di,
	output logic                   irq_n,
	output logic [1:0]             joy_p54,
	output logic                   speed,
	output gb_mem_pkg::wram_bank_t wram_bank,
	output logic                   vram_bank,
	output logic                   boot_rom_enabled
);

	gb_irq_pkg::irq_mask_t event_in;
	logic                  prepare_switch;
	gb_mem_pkg::data_t     ff72_q, ff73_q, ff74_q;
	logic [2:0]            ff75_q;

	gb_cpu_bus_if bus_if ();
	gb_irq_if     irq_if ();

	// event lines into IF bit order
	always_comb begin
		event_in = '0; // joypad handled from joy_din
		event_in[gb_irq_pkg::irq_vblank] = vblank_irq;
		event_in[gb_irq_pkg::irq_lcd]    = video_irq;
		event_in[gb_irq_pkg::irq_timer]  = timer_irq;
		event_in[gb_irq_pkg::irq_serial] = serial_irq;
	end

	// ----------------------------------------
	// decode / execute / result
	// ----------------------------------------
	gb_addr_decode u_dec (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu(ce_cpu),
		.cpu_addr(cpu_addr), .cpu_do(cpu_do), .cpu_wr_n(cpu_wr_n),
		.is_gbc(is_gbc), .is_gbc_game(is_gbc_game),
		.boot_rom_enabled(boot_rom_enabled), .bus(bus_if.dec)
	);

	gb_irq_ctrl u_irq (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu(ce_cpu),
		.bus(bus_if.regs), .irq(irq_if.ctrl),
		.cpu_iorq_n(cpu_iorq_n), .cpu_m1_n(cpu_m1_n),
		.event_in(event_in), .joy_din(joy_din), .irq_n(irq_n)
	);

	gb_sys_regs u_regs (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu(ce_cpu),
		.bus(bus_if.regs), .cpu_stop(cpu_stop),
		.joy_p54(joy_p54), .wram_bank(wram_bank), .vram_bank(vram_bank),
		.speed(speed), .prepare_switch(prepare_switch),
		.boot_rom_enabled(boot_rom_enabled),
		.ff72_q(ff72_q), .ff73_q(ff73_q), .ff74_q(ff74_q), .ff75_q(ff75_q)
	);

	gb_read_mux u_mux (
		.bus(bus_if.mux), .irq(irq_if.mux),
		.ext_di(ext_di), .joy_din(joy_din), .joy_p54(joy_p54),
		.wram_bank(wram_bank), .vram_bank(vram_bank),
		.speed(speed), .prepare_switch(prepare_switch),
		.ff72_q(ff72_q), .ff73_q(ff73_q), .ff74_q(ff74_q), .ff75_q(ff75_q),
		.cpu_di(cpu_di)
	);

endmodule

// File: rtl/gb_irq_ctrl.sv
module gb_irq_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  ce_cpu,
	gb_cpu_bus_if.regs            bus,
	gb_irq_if.ctrl                irq,
	input  logic                  cpu_iorq_n,
	input  logic                  cpu_m1_n,
	input  gb_irq_pkg::irq_mask_t event_in, // joypad bit comes from joy_din
	input  logic [3:0]            joy_din,
	output logic                  irq_n
);

	localparam int ev_w = gb_irq_pkg::irq_count - 1; // vblank .. serial

	gb_irq_pkg::irq_mask_t if_r;
	gb_irq_pkg::ie_t       ie_r;
	gb_irq_pkg::irq_mask_t pending;
	gb_irq_pkg::irq_mask_t top_pend; // highest priority pending bit only
	gb_irq_pkg::irq_mask_t set_mask;
	gb_irq_pkg::irq_mask_t if_nxt;

	logic [ev_w-1:0] ev_s1, ev_s2;         // event sample, previous sample
	logic [3:0]      joy_s1, joy_s2, joy_s3;
	logic            old_ack;
	logic            ack_done;

	assign irq.if_q = if_r;
	assign irq.ie_q = ie_r;
	assign irq.ack  = ~cpu_iorq_n & ~cpu_m1_n;

	assign pending  = if_r & ie_r[gb_irq_pkg::irq_count-1:0];
	assign top_pend = pending & (~pending + 1'b1); // isolate lowest set bit
	assign irq_n    = ~|pending;
	assign ack_done = old_ack & ~irq.ack; // ack cycle just ended

	// ----------------------------------------
	// vector, lowest index wins
	// ----------------------------------------
	always_comb begin
		irq.vector = '0; // nothing pending
		for (int i = gb_irq_pkg::irq_count - 1; i >= 0; i--) begin
			if (pending[i])
				irq.vector = gb_irq_pkg::irq_vec_base + gb_irq_pkg::irq_vec_step * 8'(i);
		end
	end

	// ----------------------------------------
	// flag update
	// ----------------------------------------
	always_comb begin
		set_mask = '0;
		set_mask[ev_w-1:0] = ev_s1 & ~ev_s2; // rising edges
		set_mask[gb_irq_pkg::irq_joypad] = |(~joy_s2 & joy_s3); // any line pulled low
		if_nxt = if_r | set_mask;
		if (ack_done)
			if_nxt = if_nxt & ~top_pend; // serviced source
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r    <= '0;
			ie_r    <= '0;
			ev_s1   <= '0;
			ev_s2   <= '0;
			joy_s1  <= '1; // lines idle high
			joy_s2  <= '1;
			joy_s3  <= '1;
			old_ack <= 1'b0;
		end else if (ce_cpu) begin
			ev_s1   <= event_in[ev_w-1:0];
			ev_s2   <= ev_s1;
			joy_s1  <= joy_din;
			joy_s2  <= joy_s1;
			joy_s3  <= joy_s2;
			old_ack <= irq.ack;

			// cpu writes win over events and ack
			if (bus.wr_stb && bus.sel == gb_mem_pkg::sel_if)
				if_r <= bus.wdata[gb_irq_pkg::irq_count-1:0];
			else
				if_r <= if_nxt;

			if (bus.wr_stb && bus.sel == gb_mem_pkg::sel_ie)
				ie_r <= bus.wdata; // all 8 bits kept
		end
	end

endmodule

// File: rtl/gb_irq_if.sv
interface gb_irq_if;

	gb_irq_pkg::irq_mask_t if_q;   // IF flags
	gb_irq_pkg::ie_t       ie_q;   // IE register
	logic                  ack;    // iorq and m1 low
	logic [7:0]            vector; // rst address for the ack cycle

	modport ctrl (
		output if_q,
		output ie_q,
		output ack,
		output vector
	);

	modport mux (
		input if_q,
		input ie_q,
		input ack,
		input vector
	);

endinterface

// File: rtl/gb_irq_pkg.sv
package gb_irq_pkg;

	// ----------------------------------------
	// interrupt sources
	// ----------------------------------------
	localparam int irq_count = 5;

	// priority order, bit position == enum value
	typedef enum logic [2:0] {
		irq_vblank = 3'd0,
		irq_lcd    = 3'd1, // lcd stat
		irq_timer  = 3'd2,
		irq_serial = 3'd3,
		irq_joypad = 3'd4
	} irq_src_e;

	// rst vectors 40, 48, 50, 58, 60
	localparam logic [7:0] irq_vec_base = 8'h40;
	localparam logic [7:0] irq_vec_step = 8'h08;

	typedef logic [irq_count-1:0] irq_mask_t; // IF and pending flags

	// upper three bits are kept for readback only
	typedef logic [7:0] ie_t;

endpackage

// File: rtl/gb_mem_pkg.sv
package gb_mem_pkg;

	// ----------------------------------------
	// cpu bus widths
	// ----------------------------------------
	localparam int data_w = 8;
	localparam int addr_w = 16;

	typedef logic [data_w-1:0] data_t;
	typedef logic [addr_w-1:0] addr_t;

	// ----------------------------------------
	// memory map
	// ----------------------------------------
	// rom, vram, cart ram, wram, echo and oam all sit below the io page
	localparam addr_t addr_io_base   = 16'hFF00; // first io register
	localparam addr_t addr_hram_base = 16'hFF80; // zero page ram up to fffe

	// io registers handled here
	localparam addr_t addr_joy  = 16'hFF00; // P1 line select
	localparam addr_t addr_if   = 16'hFF0F; // interrupt flags
	localparam addr_t addr_key1 = 16'hFF4D; // prepare speed switch
	localparam addr_t addr_vbk  = 16'hFF4F; // vram bank
	localparam addr_t addr_boot = 16'hFF50; // boot rom disable
	localparam addr_t addr_svbk = 16'hFF70; // wram bank
	localparam addr_t addr_ff72 = 16'hFF72; // unused colour regs
	localparam addr_t addr_ff73 = 16'hFF73;
	localparam addr_t addr_ff74 = 16'hFF74;
	localparam addr_t addr_ff75 = 16'hFF75;
	localparam addr_t addr_ie   = 16'hFFFF; // interrupt enable

	// work ram banking, bank 0 is never selectable in the upper window
	localparam int wram_bank_w = 3;
	typedef logic [wram_bank_w-1:0] wram_bank_t;
	localparam wram_bank_t wram_bank_reset = 3'd1;

	localparam data_t open_value = 8'hFF; // pulled-up bus

	// one select per access
	typedef enum logic [3:0] {
		sel_none,
		sel_ext,   // any memory region
		sel_joy,
		sel_if,
		sel_ie,
		sel_key1,
		sel_vbk,
		sel_svbk,
		sel_boot,
		sel_ff72,
		sel_ff73,
		sel_ff74,
		sel_ff75
	} io_sel_e;

endpackage

// File: rtl/gb_read_mux.sv
module gb_read_mux (
	gb_cpu_bus_if.mux              bus,
	gb_irq_if.mux                  irq,
	input  gb_mem_pkg::data_t      ext_di,
	input  logic [3:0]             joy_din,
	input  logic [1:0]             joy_p54,
	input  gb_mem_pkg::wram_bank_t wram_bank,
	input  logic                   vram_bank,
	input  logic                   speed,
	input  logic                   prepare_switch,
	input  gb_mem_pkg::data_t      ff72_q,
	input  gb_mem_pkg::data_t      ff73_q,
	input  gb_mem_pkg::data_t      ff74_q,
	input  logic [2:0]             ff75_q,
	output gb_mem_pkg::data_t      cpu_di
);

	// ----------------------------------------
	// cpu read data
	// ----------------------------------------
	always_comb begin
		if (irq.ack) begin
			cpu_di = irq.vector; // ack cycle overrides the address
		end else begin
			case (bus.sel)
				gb_mem_pkg::sel_if:   cpu_di = {3'b111, irq.if_q};
				gb_mem_pkg::sel_svbk: cpu_di = {5'b11111, wram_bank};
				gb_mem_pkg::sel_vbk:  cpu_di = {7'h7F, vram_bank};
				gb_mem_pkg::sel_key1: cpu_di = {speed, 6'h3F, prepare_switch};
				gb_mem_pkg::sel_joy:  cpu_di = {2'b11, joy_p54, joy_din};
				gb_mem_pkg::sel_ext:  cpu_di = ext_di; // memory regions
				gb_mem_pkg::sel_ie:   cpu_di = irq.ie_q;
				gb_mem_pkg::sel_ff72: cpu_di = ff72_q;
				gb_mem_pkg::sel_ff73: cpu_di = ff73_q;
				gb_mem_pkg::sel_ff74: cpu_di = ff74_q;
				gb_mem_pkg::sel_ff75: cpu_di = {1'b1, ff75_q, 4'b1111};
				default:              cpu_di = gb_mem_pkg::open_value; // boot, unmapped
			endcase
		end
	end

endmodule

// File: rtl/gb_sys_regs.sv
module gb_sys_regs (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  logic                   ce_cpu,
	gb_cpu_bus_if.regs             bus,
	input  logic                   cpu_stop,
	output logic [1:0]             joy_p54,
	output gb_mem_pkg::wram_bank_t wram_bank,
	output logic                   vram_bank,
	output logic                   speed,
	output logic                   prepare_switch,
	output logic                   boot_rom_enabled,
	output gb_mem_pkg::data_t      ff72_q,
	output gb_mem_pkg::data_t      ff73_q,
	output gb_mem_pkg::data_t      ff74_q,
	output logic [2:0]             ff75_q
);

	gb_mem_pkg::wram_bank_t svbk_wd; // bank field of the write data
	logic                   boot_off;

	assign svbk_wd = bus.wdata[gb_mem_pkg::wram_bank_w-1:0];

	// colour unit wants 11, mono unit any odd value
	assign boot_off = bus.is_gbc ? (bus.wdata == 8'h11) : bus.wdata[0];

	// ----------------------------------------
	// register file
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54          <= 2'b00; // boot rom sets it later
			wram_bank        <= gb_mem_pkg::wram_bank_reset;
			vram_bank        <= 1'b0;
			speed            <= 1'b0; // normal speed
			prepare_switch   <= 1'b0;
			boot_rom_enabled <= 1'b1;
			ff72_q           <= '0;
			ff73_q           <= '0;
			ff74_q           <= '0;
			ff75_q           <= '0;
		end else if (ce_cpu) begin
			if (bus.wr_stb) begin
				case (bus.sel)
					gb_mem_pkg::sel_joy:  joy_p54 <= bus.wdata[5:4];
					gb_mem_pkg::sel_svbk: begin
						if (svbk_wd == '0)
							wram_bank <= gb_mem_pkg::wram_bank_reset; // 0 maps to 1
						else
							wram_bank <= svbk_wd;
					end
					gb_mem_pkg::sel_vbk:  vram_bank <= bus.wdata[0];
					gb_mem_pkg::sel_key1: prepare_switch <= bus.wdata[0]; // arm
					gb_mem_pkg::sel_boot: begin
						if (boot_off)
							boot_rom_enabled <= 1'b0; // sticky until reset
					end
					gb_mem_pkg::sel_ff72: ff72_q <= bus.wdata;
					gb_mem_pkg::sel_ff73: ff73_q <= bus.wdata;
					gb_mem_pkg::sel_ff74: ff74_q <= bus.wdata;
					gb_mem_pkg::sel_ff75: ff75_q <= bus.wdata[6:4]; // only 6:4 exist
					default: ;
				endcase
			end

			// ---- speed switch
			// stop with KEY1 armed flips the cpu clock
			if (prepare_switch && cpu_stop) begin
				speed          <= ~speed;
				prepare_switch <= 1'b0;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the gb_io testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f gb_io.f --top-module tb_gb_io -o tb_gb_io \
	&& ./obj_dir/tb_gb_io | tee /dev/stderr \
		| grep "Simulation completed successfully" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: tests/tb_gb_io_tasks.svh
`ifndef TB_GB_IO_TASKS_SVH
`define TB_GB_IO_TASKS_SVH

// ----------------------------------------
// stimulus helpers
// ----------------------------------------
function automatic gb_mem_pkg::data_t lcg_byte();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[23:16]; // middle bits, low ones repeat too fast
endfunction

task automatic next_drive_slot();
	@(posedge clk_sys);
	#5;
endtask

task automatic cpu_write(input gb_mem_pkg::addr_t a, input gb_mem_pkg::data_t d);
	next_drive_slot();
	cpu_addr = a;
	cpu_do   = d;
	cpu_wr_n = 1'b0;
	next_drive_slot(); // register loads on this edge
	cpu_wr_n = 1'b1;
endtask

task automatic cpu_read(input gb_mem_pkg::addr_t a, output gb_mem_pkg::data_t d);
	next_drive_slot();
	cpu_addr = a;
	cpu_rd_n = 1'b0;
	#10 d = cpu_di; // combinational path, settled by now
	next_drive_slot();
	cpu_rd_n = 1'b1;
endtask

// one acknowledge cycle, returns what the cpu saw
task automatic irq_ack(output gb_mem_pkg::data_t vec);
	next_drive_slot();
	cpu_iorq_n = 1'b0;
	cpu_m1_n   = 1'b0;
	#10 vec = cpu_di;
	next_drive_slot();
	cpu_iorq_n = 1'b1; // flag clears on the next edge
	cpu_m1_n   = 1'b1;
endtask

task automatic pulse_stop();
	next_drive_slot();
	cpu_stop = 1'b1;
	next_drive_slot();
	cpu_stop = 1'b0;
endtask

task automatic wait_irq_low(input int max_cycles);
	int n;
	n = 0;
	while (irq_n !== 1'b0) begin
		if (n == max_cycles) begin
			$display("irq_n stayed high for %0d cycles, no interrupt request", max_cycles);
			$display("Simulation failed");
			$fatal(1, "interrupt request missing");
		end else begin
			next_drive_slot();
			n++;
		end
	end
endtask

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_data(input string name, input gb_mem_pkg::data_t got,
		input gb_mem_pkg::data_t exp);
	if (got !== exp) begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		$display("Simulation failed");
		$fatal(1, "data mismatch");
	end
endtask

task automatic check_bank(input string name, input gb_mem_pkg::wram_bank_t got,
		input gb_mem_pkg::wram_bank_t exp);
	if (got !== exp) begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		$display("Simulation failed");
		$fatal(1, "bank mismatch");
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		$display("Simulation failed");
		$fatal(1, "bit mismatch");
	end
endtask

task automatic read_expect(input gb_mem_pkg::addr_t a, input gb_mem_pkg::data_t exp,
		input string name);
	gb_mem_pkg::data_t d;
	cpu_read(a, d);
	check_data(name, d, exp);
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic test_reset_state();
	check_bank("wram_bank", wram_bank, 3'd1);
	check_bit("boot_rom_enabled", boot_rom_enabled, 1'b1);
	check_bit("speed", speed, 1'b0);
	check_bit("vram_bank", vram_bank, 1'b0);
	check_bit("irq_n", irq_n, 1'b1); // nothing enabled
	check_data("joy_p54", {6'd0, joy_p54}, 8'h00);
	read_expect(16'hFF0F, 8'hE0, "cpu_di (IF)"); // top three bits read 1
	read_expect(16'hFF60, 8'hFF, "cpu_di (unmapped)");
endtask

task automatic test_reg_readback();
	gb_mem_pkg::data_t      d;
	gb_mem_pkg::wram_bank_t bank;
	next_drive_slot();
	is_gbc      = 1'b1;
	is_gbc_game = 1'b1;
	d = lcg_byte();
	cpu_write(16'hFF72, d);
	read_expect(16'hFF72, d, "cpu_di (FF72)");
	d = lcg_byte();
	cpu_write(16'hFF73, d);
	read_expect(16'hFF73, d, "cpu_di (FF73)");
	d = lcg_byte();
	cpu_write(16'hFF74, d);
	read_expect(16'hFF74, d, "cpu_di (FF74)");
	d = lcg_byte();
	cpu_write(16'hFF75, d);
	read_expect(16'hFF75, {1'b1, d[6:4], 4'hF}, "cpu_di (FF75)"); // bits 6:4 only
	cpu_write(16'hFF70, 8'h06); // move off the reset bank first
	check_bank("wram_bank", wram_bank, 3'd6);
	cpu_write(16'hFF70, 8'h00); // bank 0 maps to 1
	check_bank("wram_bank", wram_bank, 3'd1);
	read_expect(16'hFF70, 8'hF9, "cpu_di (SVBK)");
	d    = lcg_byte();
	bank = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
	cpu_write(16'hFF70, d);
	check_bank("wram_bank", wram_bank, bank);
	read_expect(16'hFF70, {5'b11111, bank}, "cpu_di (SVBK)");
	d = lcg_byte();
	cpu_write(16'hFF4F, d);
	check_bit("vram_bank", vram_bank, d[0]);
	read_expect(16'hFF4F, {7'h7F, d[0]}, "cpu_di (VBK)");
	cpu_write(16'hFF4F, ~d); // flip bit 0 for the other bank
	check_bit("vram_bank", vram_bank, ~d[0]);
	read_expect(16'hFF4F, {7'h7F, ~d[0]}, "cpu_di (VBK)");
	d = lcg_byte();
	cpu_write(16'hFF00, d);
	read_expect(16'hFF00, {2'b11, d[5:4], joy_din}, "cpu_di (P1)");

	// mono hardware, colour regs gone
	next_drive_slot();
	is_gbc      = 1'b0;
	is_gbc_game = 1'b0;
	read_expect(16'hFF70, 8'hFF, "cpu_di (FF70 mono)");
	read_expect(16'hFF72, 8'hFF, "cpu_di (FF72 mono)");
	cpu_write(16'hFF70, {5'd0, ~bank});
	check_bank("wram_bank", wram_bank, bank);
endtask

task automatic test_irq_priority();
	gb_mem_pkg::data_t vec;
	next_drive_slot();
	is_gbc      = 1'b1;
	is_gbc_game = 1'b1;
	cpu_write(16'hFF0F, 8'h00);
	cpu_write(16'hFFFF, 8'h1F); // all five sources
	read_expect(16'hFFFF, 8'h1F, "cpu_di (IE)");
	next_drive_slot();
	timer_irq  = 1'b1;
	vblank_irq = 1'b1; // both in the same cycle
	wait_irq_low(8);
	timer_irq  = 1'b0;
	vblank_irq = 1'b0;
	irq_ack(vec);
	check_data("cpu_di (ack vector)", vec, 8'h40); // vblank wins
	read_expect(16'hFF0F, 8'hE4, "cpu_di (IF)"); // timer still pending
	check_bit("irq_n", irq_n, 1'b0);
	irq_ack(vec);
	check_data("cpu_di (ack vector)", vec, 8'h50);
	read_expect(16'hFF0F, 8'hE0, "cpu_di (IF)");
	check_bit("irq_n", irq_n, 1'b1);
	cpu_write(16'hFF0F, 8'h1F); // flags set by software
	check_bit("irq_n", irq_n, 1'b0);
	cpu_write(16'hFFFF, 8'h00);
	check_bit("irq_n", irq_n, 1'b1);
	cpu_write(16'hFF0F, 8'h00);
endtask

task automatic test_joypad_irq();
	cpu_write(16'hFFFF, 8'h10); // joypad only
	next_drive_slot();
	joy_din = 4'b1110; // line 0 pressed
	wait_irq_low(8);
	read_expect(16'hFF0F, 8'hF0, "cpu_di (IF)");
	cpu_write(16'hFF00, 8'h20);
	check_data("joy_p54", {6'd0, joy_p54}, 8'h02);
	read_expect(16'hFF00, 8'hEE, "cpu_di (P1)");
	next_drive_slot();
	joy_din = 4'hF; // release, no flag on rising lines
	cpu_write(16'hFFFF, 8'h00);
	cpu_write(16'hFF0F, 8'h00);
endtask

task automatic test_speed_switch();
	cpu_write(16'hFF4D, 8'h01); // arm
	read_expect(16'hFF4D, 8'h7F, "cpu_di (KEY1)");
	pulse_stop();
	check_bit("speed", speed, 1'b1);
	read_expect(16'hFF4D, 8'hFE, "cpu_di (KEY1)"); // double speed, disarmed
	next_drive_slot();
	is_gbc_game = 1'b0;
	cpu_write(16'hFF4D, 8'h01); // mono game, key1 hidden
	pulse_stop();
	check_bit("speed", speed, 1'b1);
	read_expect(16'hFF4D, 8'hFF, "cpu_di (KEY1 mono game)");
	next_drive_slot();
	is_gbc_game = 1'b1;
endtask

task automatic test_boot_and_ext();
	gb_mem_pkg::data_t d;
	gb_mem_pkg::addr_t ext_addrs [3];
	ext_addrs[0] = 16'h0000; // rom
	ext_addrs[1] = 16'hC000; // wram
	ext_addrs[2] = 16'hFF80; // zero page
	next_drive_slot();
	is_gbc_game = 1'b0;
	cpu_write(16'hFF70, 8'h03); // boot rom still on, svbk reachable
	check_bank("wram_bank", wram_bank, 3'd3);
	cpu_write(16'hFF50, 8'h01); // mono unlock value
	check_bit("boot_rom_enabled", boot_rom_enabled, 1'b1);
	cpu_write(16'hFF50, 8'h11);
	check_bit("boot_rom_enabled", boot_rom_enabled, 1'b0);
	cpu_write(16'hFF70, 8'h06);
	check_bank("wram_bank", wram_bank, 3'd3);
	read_expect(16'hFF70, 8'hFF, "cpu_di (SVBK mono game)");
	for (int i = 0; i < 3; i++) begin
		next_drive_slot();
		d      = lcg_byte();
		ext_di = d;
		read_expect(ext_addrs[i], d, "cpu_di (ext)");
	end
endtask

`endif

// File: tests/tb_gb_io.sv
module tb_gb_io;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests   = 6;
	localparam int clk_period  = 100;
	localparam int cycles_each = 200; // budget per directed test

	logic                   clk_sys;
	logic                   reset_ss;
	logic                   ce_cpu;
	logic                   is_gbc;
	logic                   is_gbc_game;
	gb_mem_pkg::addr_t      cpu_addr;
	gb_mem_pkg::data_t      cpu_do;
	logic                   cpu_wr_n;
	logic                   cpu_rd_n;
	logic                   cpu_iorq_n;
	logic                   cpu_m1_n;
	logic                   cpu_stop;
	gb_mem_pkg::data_t      ext_di;   // stands in for rom, wram and the rest
	logic [3:0]             joy_din;  // active low buttons
	logic                   vblank_irq;
	logic                   video_irq;
	logic                   timer_irq;
	logic                   serial_irq;
	gb_mem_pkg::data_t      cpu_di;
	logic                   irq_n;
	logic [1:0]             joy_p54;
	logic                   speed;
	gb_mem_pkg::wram_bank_t wram_bank;
	logic                   vram_bank;
	logic                   boot_rom_enabled;

	int unsigned lcg_state = 2023; // lcg seed

	gb_io_top dut_i (.*);

	`include "tb_gb_io_tasks.svh"

	// ----------------------------------------
	// clock and watchdog
	// ----------------------------------------
	initial clk_sys = 1'b0;
	always #(clk_period / 2) clk_sys = ~clk_sys;

	initial begin
		#(num_tests * cycles_each * clk_period);
		$display("timeout: the directed tests did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		reset_ss    = 1'b1;
		ce_cpu      = 1'b1; // cpu runs every cycle
		is_gbc      = 1'b0;
		is_gbc_game = 1'b0;
		cpu_addr    = '0;
		cpu_do      = '0;
		cpu_wr_n    = 1'b1; // bus idle
		cpu_rd_n    = 1'b1;
		cpu_iorq_n  = 1'b1;
		cpu_m1_n    = 1'b1;
		cpu_stop    = 1'b0;
		ext_di      = '0;
		joy_din     = 4'hF; // nothing pressed
		vblank_irq  = 1'b0;
		video_irq   = 1'b0;
		timer_irq   = 1'b0;
		serial_irq  = 1'b0;

		repeat (4) @(posedge clk_sys);
		#5;
		reset_ss = 1'b0;

		test_reset_state();
		test_reg_readback();
		test_irq_priority();
		test_joypad_irq();
		test_speed_switch();
		test_boot_and_ext();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
